// ==== run.sh ====
#!/bin/bash
# build and run the detector control testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_detector_control -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_detector_control > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator returned status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1

// ==== src/command_sequencer.sv ====
module command_sequencer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  detector_pkg::byte_t         cmd_byte,
  input  logic                        cmd_valid,
  input  logic                        frame_done,
  input  detector_pkg::detector_cfg_t cfg,
  input  logic                        word_ready,
  input  logic                        word_done,
  output detector_pkg::cmd_word_t     word,
  output logic                        word_valid,
  output logic                        busy
);

  localparam int CNT_W = $clog2(detector_pkg::CFG_WORDS);

  detector_pkg::seq_state_t state;
  logic [CNT_W-1:0]         word_cnt;
  logic                     last_word;  // word in flight ends the command

  logic                    direct_hit;
  detector_pkg::cmd_word_t direct_word;
  logic                    start_direct;
  logic                    start_cfg;
  logic                    next_cfg;
  logic                    xfer;

  // configuration word n built from the stored frame
  function automatic detector_pkg::cmd_word_t cfg_word(
    input detector_pkg::detector_cfg_t c,
    input logic [CNT_W-1:0]            n
  );
    case (n)
      2'd0:    cfg_word = {detector_pkg::OP_BIAS, 12'h000, c.bias};
      2'd1:    cfg_word = {detector_pkg::OP_RANGE, 12'h000, c.range};
      2'd2:    cfg_word = {detector_pkg::OP_TIMING, 4'h0, c.gate, c.deadtime};
      default: cfg_word = {detector_pkg::OP_FEEDBACK, c.period[11:0], c.temperature};
    endcase
  endfunction

  // direct table lookup, unknown codes miss
  always_comb begin
    direct_hit  = 1'b0;
    direct_word = '0;
    for (int i = 0; i < detector_pkg::DIRECT_CNT; i++) begin
      if (cmd_byte == detector_pkg::DIRECT_CODE[i]) begin
        direct_hit  = 1'b1;
        direct_word = detector_pkg::DIRECT_WORD[i];
      end
    end
  end

  assign start_cfg    = (state == detector_pkg::IDLE) && frame_done;
  assign start_direct = (state == detector_pkg::IDLE) && !frame_done && cmd_valid && direct_hit;
  assign next_cfg     = (state == detector_pkg::WAIT_DONE) && word_done && !last_word;
  assign xfer         = word_valid && word_ready;
  assign busy         = (state != detector_pkg::IDLE);

  //////////////////////////////
  // FSM
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= detector_pkg::IDLE;
      word_valid <= 1'b0;
      word_cnt   <= '0;
      last_word  <= 1'b0;
    end else begin
      case (state)
        detector_pkg::IDLE: begin
          if (start_cfg) begin
            state      <= detector_pkg::CONFIG;
            word_valid <= 1'b1;
            word_cnt   <= '0;
            last_word  <= 1'b0;
          end else if (start_direct) begin
            state      <= detector_pkg::DIRECT;
            word_valid <= 1'b1;
            last_word  <= 1'b1; // one word only
          end
        end
        detector_pkg::DIRECT, detector_pkg::CONFIG: begin
          if (xfer) begin
            state      <= detector_pkg::WAIT_DONE;
            word_valid <= 1'b0;
          end
        end
        detector_pkg::WAIT_DONE: begin
          if (next_cfg) begin
            state      <= detector_pkg::CONFIG;
            word_valid <= 1'b1;
            word_cnt   <= word_cnt + 1'b1;
            last_word  <= (word_cnt == CNT_W'(detector_pkg::CFG_WORDS - 2));
          end else if (word_done) begin
            state <= detector_pkg::IDLE;
          end
        end
        default: state <= detector_pkg::IDLE;
      endcase
    end
  end

  // word payload, held until the serializer takes it
  always_ff @(posedge clk) begin
    if (start_cfg) begin
      word <= cfg_word(cfg, '0);
    end else if (start_direct) begin
      word <= direct_word;
    end else if (next_cfg) begin
      word <= cfg_word(cfg, word_cnt + 1'b1);
    end
  end

endmodule

// ==== src/detector_control.sv ====
module detector_control #(
  parameter int clks_per_bit = 434
) (
  input  logic                clk,
  input  logic                rst_n,
  input  detector_pkg::byte_t cmd_byte,
  input  logic                cmd_valid,
  input  detector_pkg::byte_t cfg_byte,
  input  logic                cfg_valid,
  output logic                tx,
  output logic                busy
);

  detector_pkg::frame_byte_t   param_byte;
  logic                        frame_done;
  detector_pkg::detector_cfg_t cfg;
  detector_pkg::cmd_word_t     word;
  logic                        word_valid;
  logic                        word_ready;
  logic                        word_done;

  //////////////////////////////
  // frame input path
  //////////////////////////////
  frame_parser u_frame_parser (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_byte   (cfg_byte),
    .cfg_valid  (cfg_valid),
    .busy       (busy),
    .param_byte (param_byte),
    .frame_done (frame_done)
  );

  detector_regs u_detector_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .param_byte (param_byte),
    .cfg        (cfg)
  );

  //////////////////////////////
  // command and serial output
  //////////////////////////////
  command_sequencer u_command_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_byte   (cmd_byte),
    .cmd_valid  (cmd_valid),
    .frame_done (frame_done),
    .cfg        (cfg),
    .word_ready (word_ready),
    .word_done  (word_done),
    .word       (word),
    .word_valid (word_valid),
    .busy       (busy)
  );

  word_serializer #(
    .clks_per_bit (clks_per_bit)
  ) u_word_serializer (
    .clk        (clk),
    .rst_n      (rst_n),
    .word       (word),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .word_done  (word_done),
    .tx         (tx)
  );

endmodule

// ==== src/detector_pkg.sv ====
package detector_pkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] param_t;
  typedef logic [31:0] cmd_word_t;  // opcode in 31:28, payload below
  typedef logic [3:0]  opcode_t;
  typedef logic [3:0]  frame_idx_t; // 1..11 after the header

  // one parameter byte tagged with its frame position
  typedef struct packed {
    logic       valid;
    frame_idx_t idx;
    byte_t      data;
  } frame_byte_t;

  typedef struct packed {
    param_t bias;
    param_t range;        // range judge voltage
    byte_t  gate;         // gate control byte
    param_t deadtime;
    param_t period;       // temperature feedback period
    param_t temperature;  // temperature setpoint
  } detector_cfg_t;

  ////////////////////////////////
  // frame and command constants
  ////////////////////////////////
  localparam byte_t      FRAME_HEADER = 8'hB7;
  localparam frame_idx_t FRAME_LEN    = 4'd11;
  localparam int         CFG_WORDS    = 4;

  localparam opcode_t OP_BIAS     = 4'd1;
  localparam opcode_t OP_RANGE    = 4'd2;
  localparam opcode_t OP_FEEDBACK = 4'd6;
  localparam opcode_t OP_TIMING   = 4'd8;

  // single-byte commands and the fixed words they send
  localparam int DIRECT_CNT = 11;
  localparam byte_t DIRECT_CODE [DIRECT_CNT] = '{
    8'hC6, 8'hC7, 8'hC8, 8'hC9, 8'hCA, 8'hCB, 8'hCC, 8'hCD, 8'hCE, 8'hCF, 8'hB2};
  localparam cmd_word_t DIRECT_WORD [DIRECT_CNT] = '{
    32'h63E74F9A, 32'h40007F00, 32'h30001F80, 32'h80000010, 32'h40000000, 32'h50000000,
    32'h60000000, 32'h70100000, 32'h80000000, 32'hE000E000, 32'hF000E000};

  typedef enum logic [1:0] {IDLE, DIRECT, CONFIG, WAIT_DONE} seq_state_t;

endpackage

// ==== src/detector_regs.sv ====
module detector_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  detector_pkg::frame_byte_t   param_byte,
  output detector_pkg::detector_cfg_t cfg
);

  detector_pkg::byte_t d;

  assign d = param_byte.data;

  //////////////////////////////
  // field writes, high byte first
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (param_byte.valid) begin
      case (param_byte.idx)
        4'd1: begin
          cfg           <= '0;  // new frame, drop old fields
          cfg.bias[15:8] <= d;
        end
        4'd2:  cfg.bias[7:0]         <= d;
        4'd3:  cfg.range[15:8]       <= d;
        4'd4:  cfg.range[7:0]        <= d;
        4'd5:  cfg.gate              <= d;
        4'd6:  cfg.deadtime[15:8]    <= d;
        4'd7:  cfg.deadtime[7:0]     <= d;
        4'd8:  cfg.period[15:8]      <= d;
        4'd9:  cfg.period[7:0]       <= d;
        4'd10: cfg.temperature[15:8] <= d;
        4'd11: cfg.temperature[7:0]  <= d;
        default: begin
          cfg <= cfg; // positions 0 and 12..15 never tagged
        end
      endcase
    end
  end

endmodule

// ==== src/frame_parser.sv ====
module frame_parser (
  input  logic                      clk,
  input  logic                      rst_n,
  input  detector_pkg::byte_t       cfg_byte,
  input  logic                      cfg_valid,
  input  logic                      busy,
  output detector_pkg::frame_byte_t param_byte,
  output logic                      frame_done
);

  detector_pkg::frame_idx_t cnt;     // 0 = waiting for header
  logic                     tag_valid;
  detector_pkg::frame_idx_t tag_idx;
  detector_pkg::byte_t      tag_data;

  logic take_param;

  // a byte past the header is a parameter byte
  assign take_param = cfg_valid && !busy && (cnt != '0);

  //////////////////////////////
  // position counter
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt        <= '0;
      tag_valid  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      tag_valid  <= take_param;
      frame_done <= 1'b0;
      if (busy) begin
        cnt <= '0;  // bytes during a send are dropped
      end else if (cfg_valid) begin
        if (cnt == '0) begin
          if (cfg_byte == detector_pkg::FRAME_HEADER) begin
            cnt <= 4'd1;
          end
        end else if (cnt == detector_pkg::FRAME_LEN) begin
          cnt        <= '0;
          frame_done <= 1'b1; // lines up with the store of byte 11
        end else begin
          cnt <= cnt + 4'd1;
        end
      end
    end
  end

  // tag payload, qualified by tag_valid
  always_ff @(posedge clk) begin
    if (take_param) begin
      tag_idx  <= cnt;
      tag_data <= cfg_byte;
    end
  end

  assign param_byte = '{valid: tag_valid, idx: tag_idx, data: tag_data};

endmodule

// ==== src/word_serializer.sv ====
module word_serializer #(
  parameter int clks_per_bit = 434
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  detector_pkg::cmd_word_t word,
  input  logic                    word_valid,
  output logic                    word_ready,
  output logic                    word_done,
  output logic                    tx
);

  localparam int BAUD_W = $clog2(clks_per_bit + 1);

  logic              active;
  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_cnt;   // 0 start, 1..8 data, 9 stop
  logic [1:0]        byte_cnt;
  logic [9:0]        frame_q;   // stop, data, start, sent from bit 0
  logic [23:0]       rest_q;    // bytes still to go, next one on top

  logic xfer;
  logic bit_end;
  logic byte_end;

  assign xfer       = word_valid && word_ready;
  assign word_ready = !active;
  assign bit_end    = active && (baud_cnt == BAUD_W'(clks_per_bit - 1));
  assign byte_end   = bit_end && (bit_cnt == 4'd9);
  assign tx         = frame_q[0];

  //////////////////////////////
  // baud, bit and byte counters
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active    <= 1'b0;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      byte_cnt  <= '0;
      word_done <= 1'b0;
      frame_q   <= '1;  // line idles high
    end else begin
      word_done <= 1'b0;
      if (xfer) begin
        active   <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
        byte_cnt <= '0;
        frame_q  <= {1'b1, word[31:24], 1'b0};
      end else if (active) begin
        baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
        if (byte_end) begin
          bit_cnt <= '0;
          if (byte_cnt == 2'd3) begin
            active    <= 1'b0;
            word_done <= 1'b1;   // stop bit of byte 4 done
            frame_q   <= '1;
          end else begin
            byte_cnt <= byte_cnt + 2'd1;
            frame_q  <= {1'b1, rest_q[23:16], 1'b0};
          end
        end else if (bit_end) begin
          bit_cnt <= bit_cnt + 4'd1;
          frame_q <= {1'b1, frame_q[9:1]}; // lsb first
        end
      end
    end
  end

  // remaining bytes, msb byte first
  always_ff @(posedge clk) begin
    if (xfer) begin
      rest_q <= word[23:0];
    end else if (byte_end) begin
      rest_q <= {rest_q[15:0], 8'h00};
    end
  end

endmodule

// ==== testbench/detector_asserts.sv ====
module detector_asserts (
  input logic                    clk,
  input logic                    rst_n,
  input detector_pkg::cmd_word_t word,
  input logic                    word_valid,
  input logic                    word_ready,
  input logic                    word_done,
  input logic                    tx,
  input logic                    busy
);
  timeunit 1ns;
  timeprecision 100ps;

  logic in_flight;  // a word was taken and is not finished yet

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 1'b0;
    end else if (word_valid && word_ready) begin
      in_flight <= 1'b1;
    end else if (word_done) begin
      in_flight <= 1'b0;
    end
  end

  //////////////////////////////
  // handshake and line rules
  //////////////////////////////
  word_held: assert property (@(posedge clk) disable iff (!rst_n)
    word_valid && !word_ready |=> $stable(word))
    else $error("word changed while waiting for the serializer");

  idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx)
    else $error("tx low while busy is low");

  done_after_xfer: assert property (@(posedge clk) disable iff (!rst_n) word_done |-> in_flight)
    else $error("word_done without a word transfer before it");

endmodule

// the checked signals all meet in the top level
bind detector_control detector_asserts u_detector_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .word       (word),
  .word_valid (word_valid),
  .word_ready (word_ready),
  .word_done  (word_done),
  .tx         (tx),
  .busy       (busy)
);

// ==== testbench/detector_tests.txt ====
// kind(1 cmd, 2 frame, 3 random frames, 0 end) nbytes b0..b11 nwords w0..w3
// kind 3 puts the frame count in nbytes
1 1 C6 00 00 00 00 00 00 00 00 00 00 00 1 63E74F9A 0 0 0
1 1 C7 00 00 00 00 00 00 00 00 00 00 00 1 40007F00 0 0 0
1 1 C8 00 00 00 00 00 00 00 00 00 00 00 1 30001F80 0 0 0
1 1 C9 00 00 00 00 00 00 00 00 00 00 00 1 80000010 0 0 0
1 1 CA 00 00 00 00 00 00 00 00 00 00 00 1 40000000 0 0 0
1 1 CB 00 00 00 00 00 00 00 00 00 00 00 1 50000000 0 0 0
1 1 CC 00 00 00 00 00 00 00 00 00 00 00 1 60000000 0 0 0
1 1 CD 00 00 00 00 00 00 00 00 00 00 00 1 70100000 0 0 0
1 1 CE 00 00 00 00 00 00 00 00 00 00 00 1 80000000 0 0 0
1 1 CF 00 00 00 00 00 00 00 00 00 00 00 1 E000E000 0 0 0
1 1 B2 00 00 00 00 00 00 00 00 00 00 00 1 F000E000 0 0 0
// unknown code
1 1 55 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0 0
// fixed frame
2 C B7 12 34 0A BC 5E 01 F4 03 E8 01 90 4 10001234 20000ABC 805E01F4 63E80190
// bad header, then a good frame
2 C A5 12 34 56 78 9A BC DE F0 11 22 33 0 0 0 0 0
2 C B7 FF FF 80 01 A5 12 34 1A BC 00 64 4 1000FFFF 20008001 80A51234 6ABC0064
// random frames
3 A 00 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0 0
0 0 00 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0 0

// ==== testbench/tb_detector_control.sv ====
module tb_detector_control;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLKS_PER_BIT = 8;
  localparam int REC_W        = 19;  // fields per test record
  localparam int MAX_REC      = 32;
  localparam int RESET_CYCLES = 16;

  logic                clk;
  logic                rst_n;
  detector_pkg::byte_t cmd_byte;
  logic                cmd_valid;
  detector_pkg::byte_t cfg_byte;
  logic                cfg_valid;
  logic                tx;
  logic                busy;

  logic [31:0] tests_mem [0:REC_W*MAX_REC-1];
  logic [31:0] rng_state;
  int          errors = 0;
  int          test_errors = 0;
  int          test_cnt = 0;
  int          fail_cnt = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  detector_control #(
    .clks_per_bit (CLKS_PER_BIT)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_byte  (cmd_byte),
    .cmd_valid (cmd_valid),
    .cfg_byte  (cfg_byte),
    .cfg_valid (cfg_valid),
    .tx        (tx),
    .busy      (busy)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // run limit, set once the test file is read
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // packing of the four configuration words, b[0] is the header
  function automatic logic [31:0] expected_cfg_word(input logic [7:0] b [12], input int n);
    case (n)
      0:       return {4'h1, 12'h000, b[1], b[2]};
      1:       return {4'h2, 12'h000, b[3], b[4]};
      2:       return {4'h8, 4'h0, b[5], b[6], b[7]};
      default: return {4'h6, b[8][3:0], b[9], b[10], b[11]};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
      else begin
        $display("ERROR %0d ns: %s expected %h got %h", $time, name, exp, got);
        test_errors++;
      end
  endtask

  task automatic send_cmd(input detector_pkg::byte_t code);
    @(negedge clk);
    cmd_byte  = code;
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] b [12]);
    for (int i = 0; i < 12; i++) begin
      @(negedge clk);
      cfg_byte  = b[i];
      cfg_valid = 1'b1;
    end
    @(negedge clk);
    cfg_valid = 1'b0;
  endtask

  //////////////////////////////
  // UART decoding
  //////////////////////////////
  task automatic receive_byte(output logic [7:0] data);
    do @(negedge clk); while (tx !== 1'b0);
    repeat (CLKS_PER_BIT / 2) @(negedge clk);  // middle of start bit
    check_value("tx start bit", 32'd0, {31'd0, tx});
    check_value("busy", 32'd1, {31'd0, busy});
    for (int k = 0; k < 8; k++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[k] = tx;  // lsb first
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_value("tx stop bit", 32'd1, {31'd0, tx});
  endtask

  task automatic receive_word(output logic [31:0] w);
    logic [7:0] b;
    w = '0;
    for (int i = 0; i < 4; i++) begin
      receive_byte(b);
      w = {w[23:0], b};
    end
  endtask

  task automatic wait_idle();
    while (busy !== 1'b0) @(negedge clk);
  endtask

  task automatic expect_silence(input int n);
    repeat (n) begin
      @(negedge clk);
      check_value("tx", 32'd1, {31'd0, tx});
      check_value("busy", 32'd0, {31'd0, busy});
    end
  endtask

  task automatic expect_words(input int n, input logic [31:0] exp [4]);
    logic [31:0] got;
    if (n == 0) begin
      expect_silence(100);
    end else begin
      for (int i = 0; i < n; i++) begin
        receive_word(got);
        check_value($sformatf("tx word %0d", i), exp[i], got);
      end
      // no further start bit before busy falls
      while (busy !== 1'b0) begin
        @(negedge clk);
        check_value("tx after last word", 32'd1, {31'd0, tx});
      end
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: FAILED with %0d errors", test_cnt, name, test_errors);
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    int          base;
    int          kind;
    int          total_words;
    int          total_tests;
    logic [7:0]  b [12];
    logic [31:0] exp [4];

    rst_n     = 1'b0;
    cmd_byte  = '0;
    cmd_valid = 1'b0;
    cfg_byte  = '0;
    cfg_valid = 1'b0;
    $readmemh("testbench/detector_tests.txt", tests_mem);

    total_words = 0;
    total_tests = 1;  // idle check after reset
    for (int r = 0; r < MAX_REC && tests_mem[r*REC_W] != 0; r++) begin
      base = r * REC_W;
      if (tests_mem[base] == 3) begin
        total_words += 4 * tests_mem[base+1];
        total_tests += tests_mem[base+1];
      end else begin
        total_words += tests_mem[base+14];
        total_tests += 1;
      end
    end
    cycle_limit = RESET_CYCLES + total_words * 40 * CLKS_PER_BIT + 200 * total_tests;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    expect_silence(100);
    finish_test("idle after reset");

    rng_state = 32'h5439;
    for (int r = 0; r < MAX_REC && tests_mem[r*REC_W] != 0; r++) begin
      base = r * REC_W;
      kind = tests_mem[base];
      wait_idle();
      for (int i = 0; i < 12; i++) b[i] = tests_mem[base+2+i][7:0];
      for (int i = 0; i < 4; i++) exp[i] = tests_mem[base+15+i];
      if (kind == 1) begin
        send_cmd(b[0]);
        expect_words(tests_mem[base+14], exp);
        finish_test($sformatf("command %h", b[0]));
      end else if (kind == 2) begin
        if (tests_mem[base+14] == 4) begin
          // file words must follow the packing rule
          for (int i = 0; i < 4; i++)
            check_value($sformatf("file word %0d", i), expected_cfg_word(b, i), exp[i]);
        end
        send_frame(b);
        expect_words(tests_mem[base+14], exp);
        finish_test($sformatf("frame starting %h", b[0]));
      end else begin
        for (int f = 0; f < tests_mem[base+1]; f++) begin
          wait_idle();
          b[0] = detector_pkg::FRAME_HEADER;
          for (int i = 1; i < 12; i++) begin
            rng_state = xorshift32(rng_state);
            b[i] = rng_state[7:0];
          end
          for (int i = 0; i < 4; i++) exp[i] = expected_cfg_word(b, i);
          send_frame(b);
          expect_words(4, exp);
          finish_test($sformatf("random frame %0d", f));
        end
      end
    end

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, errors);
    if (errors == 0 && fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
src/detector_pkg.sv
src/frame_parser.sv
src/detector_regs.sv
src/command_sequencer.sv
src/word_serializer.sv
src/detector_control.sv
testbench/detector_asserts.sv
testbench/tb_detector_control.sv
